// ==== body_frame_controller.f ====
design/rate_ctrl_pkg.sv
design/rate_loop_timer.sv
design/body_frame_sequencer.sv
design/pid_axis.sv
design/body_frame_controller.sv
testbench/body_frame_controller_props.sv
testbench/body_frame_controller_tb.sv

// ==== testbench/body_frame_controller_tb.sv ====
// Rate controller testbench
`timescale 1ns/100ps
`default_nettype none

module body_frame_controller_tb;

	import rate_ctrl_pkg::*;

	localparam int LOOP_PERIOD = 16;
	localparam int CYCLE_LIMIT = 40 * LOOP_PERIOD + 200;

	logic us_clk = 1'b0;
	logic resetn;
	logic arm;
	logic signed [RATE_W-1:0] yaw_target, roll_target, pitch_target;
	logic signed [RATE_W-1:0] yaw_rotation, roll_rotation, pitch_rotation;
	wire signed [RATE_W-1:0] yaw_rate_out, roll_rate_out, pitch_rate_out;
	wire complete_signal;

	int seed = 32'hf0ba_b9b0;
	int check_errors = 0;
	int cycles = 0;

	body_frame_controller dut0 (
		.us_clk(us_clk), .resetn(resetn), .arm(arm),
		.yaw_target(yaw_target), .roll_target(roll_target), .pitch_target(pitch_target),
		.yaw_rotation(yaw_rotation), .roll_rotation(roll_rotation),
		.pitch_rotation(pitch_rotation),
		.yaw_rate_out(yaw_rate_out), .roll_rate_out(roll_rate_out),
		.pitch_rate_out(pitch_rate_out), .complete_signal(complete_signal)
	);

	always #10 us_clk = ~us_clk;

	// Run length guard
	always @(posedge us_clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: no end of test after %0d cycles", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	// New random inputs within +/- span
	task automatic drive_random(input int span);
		@(posedge us_clk);
		yaw_target     <= $random(seed) % span;
		roll_target    <= $random(seed) % span;
		pitch_target   <= $random(seed) % span;
		yaw_rotation   <= $random(seed) % span;
		roll_rotation  <= $random(seed) % span;
		pitch_rotation <= $random(seed) % span;
	endtask

	// Corner codes of the 16 bit range
	function automatic logic signed [RATE_W-1:0] corner(input int pick);
		case (pick)
			0: return 16'sh8000;
			1: return 16'sh7fff;
			2: return 16'sh0000;
			default: return -16'sd1;
		endcase
	endfunction

	task automatic drive_extreme();
		@(posedge us_clk);
		yaw_target     <= corner(($random(seed) & 32'h7fffffff) % 4);
		roll_target    <= corner(($random(seed) & 32'h7fffffff) % 4);
		pitch_target   <= corner(($random(seed) & 32'h7fffffff) % 4);
		yaw_rotation   <= corner(($random(seed) & 32'h7fffffff) % 4);
		roll_rotation  <= corner(($random(seed) & 32'h7fffffff) % 4);
		pitch_rotation <= corner(($random(seed) & 32'h7fffffff) % 4);
	endtask

	// Returns at the falling edge inside the complete_signal cycle
	task automatic wait_complete();
		@(negedge us_clk);
		while (!complete_signal) begin
			@(negedge us_clk);
		end
	endtask

	task automatic run_loops(input int n, input int span);
		for (int i = 0; i < n; i++) begin
			wait_complete();
			if (span > 0) begin
				drive_random(span);
			end else begin
				drive_extreme();
			end
		end
	endtask

	initial begin
		resetn         <= 1'b0;
		arm            <= 1'b0;
		yaw_target     <= '0;
		roll_target    <= '0;
		pitch_target   <= '0;
		yaw_rotation   <= '0;
		roll_rotation  <= '0;
		pitch_rotation <= '0;
		repeat (10) @(posedge us_clk);
		resetn <= 1'b1;
		@(negedge us_clk);
		if (complete_signal !== 1'b0 || yaw_rate_out !== '0 || roll_rate_out !== '0
				|| pitch_rate_out !== '0) begin
			check_errors++;
			$display("Error at %0t: outputs not zero after reset", $time);
		end
		drive_random(200);
		@(posedge us_clk);
		arm <= 1'b1;
		// Small errors, then errors that hit the limits
		run_loops(8, 200);
		run_loops(8, 16000);
		// Disarm for a few cycles; nothing may complete meanwhile
		@(posedge us_clk);
		arm <= 1'b0;
		repeat (6) begin
			@(negedge us_clk);
			if (complete_signal) begin
				check_errors++;
				$display("Error at %0t: update completed while disarmed", $time);
			end
		end
		@(posedge us_clk);
		arm <= 1'b1;
		run_loops(4, 3000);
		run_loops(6, 0);
		repeat (3) @(posedge us_clk);
		$display("Closing: %0d assertion failures, %0d check errors",
			dut0.props0.fail_count, check_errors);
		if (dut0.props0.fail_count == 0 && check_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/body_frame_controller_props.sv ====
// Rate controller reference checks
`timescale 1ns/100ps
`default_nettype none

module body_frame_controller_props #(
	parameter int LOOP_PERIOD = 16,
	parameter int YAW_KP      = 6,
	parameter int YAW_KI      = 1,
	parameter int YAW_KD      = 0,
	parameter int ROLL_KP     = 8,
	parameter int ROLL_KI     = 1,
	parameter int ROLL_KD     = 4,
	parameter int PITCH_KP    = 8,
	parameter int PITCH_KI    = 1,
	parameter int PITCH_KD    = 4,
	parameter int GAIN_SHIFT  = 3,
	parameter int RATE_LIMIT  = 4000,
	parameter int INT_LIMIT   = 16000
) (
	input wire                                    us_clk,
	input wire                                    resetn,
	input wire                                    arm,
	input wire signed [rate_ctrl_pkg::RATE_W-1:0] yaw_target,
	input wire signed [rate_ctrl_pkg::RATE_W-1:0] roll_target,
	input wire signed [rate_ctrl_pkg::RATE_W-1:0] pitch_target,
	input wire signed [rate_ctrl_pkg::RATE_W-1:0] yaw_rotation,
	input wire signed [rate_ctrl_pkg::RATE_W-1:0] roll_rotation,
	input wire signed [rate_ctrl_pkg::RATE_W-1:0] pitch_rotation,
	input wire signed [rate_ctrl_pkg::RATE_W-1:0] yaw_rate_out,
	input wire signed [rate_ctrl_pkg::RATE_W-1:0] roll_rate_out,
	input wire signed [rate_ctrl_pkg::RATE_W-1:0] pitch_rate_out,
	input wire                                    complete_signal
);

	import rate_ctrl_pkg::*;

	int fail_count = 0;

	// Model history per axis
	longint yaw_integ, roll_integ, pitch_integ;
	longint yaw_prev, roll_prev, pitch_prev;

	// Expected results for the inputs now on the ports
	longint yaw_exp, roll_exp, pitch_exp;
	longint yaw_integ_n, roll_integ_n, pitch_integ_n;
	longint yaw_err, roll_err, pitch_err;

	// Body-frame sign flip, most negative code goes to the maximum
	function automatic longint flip(input longint x);
		if (x == -(longint'(1) << (RATE_W - 1))) begin
			return (longint'(1) << (RATE_W - 1)) - 1;
		end
		return -x;
	endfunction

	function automatic longint limit(input longint x, input longint lim);
		if (x > lim) begin
			return lim;
		end else if (x < -lim) begin
			return -lim;
		end
		return x;
	endfunction

	// One PID step: error, clamped integral, derivative, shift, clamp
	task automatic axis_step(
		input  longint tgt, input longint act,
		input  longint kp, input longint ki, input longint kd,
		input  longint integ, input longint prev,
		output longint out, output longint integ_n, output longint err
	);
		longint sum;
		err     = tgt - act;
		integ_n = limit(integ + err, INT_LIMIT);
		sum     = kp * err + ki * integ_n + kd * (err - prev);
		// Floor division by a power of two, as an arithmetic shift would do
		if (sum < 0) begin
			sum = -((-sum + (longint'(1) << GAIN_SHIFT) - 1) >> GAIN_SHIFT);
		end else begin
			sum = sum >> GAIN_SHIFT;
		end
		out = limit(sum, RATE_LIMIT);
	endtask

	always_comb begin
		axis_step(yaw_target, flip(yaw_rotation), YAW_KP, YAW_KI, YAW_KD,
			yaw_integ, yaw_prev, yaw_exp, yaw_integ_n, yaw_err);
		axis_step(roll_target, roll_rotation, ROLL_KP, ROLL_KI, ROLL_KD,
			roll_integ, roll_prev, roll_exp, roll_integ_n, roll_err);
		axis_step(pitch_target, flip(pitch_rotation), PITCH_KP, PITCH_KI, PITCH_KD,
			pitch_integ, pitch_prev, pitch_exp, pitch_integ_n, pitch_err);
	end

	// History advances once per completed update, cleared while disarmed
	always @(posedge us_clk or negedge resetn) begin
		if (!resetn || !arm) begin
			yaw_integ   <= 0;
			roll_integ  <= 0;
			pitch_integ <= 0;
			yaw_prev    <= 0;
			roll_prev   <= 0;
			pitch_prev  <= 0;
		end else if (complete_signal) begin
			yaw_integ   <= yaw_integ_n;
			roll_integ  <= roll_integ_n;
			pitch_integ <= pitch_integ_n;
			yaw_prev    <= yaw_err;
			roll_prev   <= roll_err;
			pitch_prev  <= pitch_err;
		end
	end

	complete_one_cycle: assert property (@(posedge us_clk) disable iff (!resetn)
		complete_signal |=> !complete_signal [*(LOOP_PERIOD-1)])
		else begin
			fail_count++;
			$error("complete_signal pulsed again within one loop period");
		end

	complete_period: assert property (@(posedge us_clk) disable iff (!resetn)
		complete_signal ##1 arm [*LOOP_PERIOD] |-> complete_signal)
		else begin
			fail_count++;
			$error("complete_signal missing one loop period after the last");
		end

	first_after_arm: assert property (@(posedge us_clk) disable iff (!resetn)
		$rose(arm) ##0 arm [*(LOOP_PERIOD+6)] |=> complete_signal)
		else begin
			fail_count++;
			$error("first complete_signal not at LOOP_PERIOD+6 after arm");
		end

	quiet_after_arm: assert property (@(posedge us_clk) disable iff (!resetn)
		$rose(arm) |-> !complete_signal [*(LOOP_PERIOD+6)])
		else begin
			fail_count++;
			$error("complete_signal came early after arm");
		end

	no_update_disarmed: assert property (@(posedge us_clk) disable iff (!resetn)
		!arm |=> !complete_signal)
		else begin
			fail_count++;
			$error("complete_signal while disarmed");
		end

	outputs_stable: assert property (@(posedge us_clk) disable iff (!resetn)
		!complete_signal |-> $stable(yaw_rate_out) && $stable(roll_rate_out)
			&& $stable(pitch_rate_out))
		else begin
			fail_count++;
			$error("rate output moved outside an update");
		end

	outputs_in_range: assert property (@(posedge us_clk) disable iff (!resetn)
		yaw_rate_out <= RATE_LIMIT && yaw_rate_out >= -RATE_LIMIT
			&& roll_rate_out <= RATE_LIMIT && roll_rate_out >= -RATE_LIMIT
			&& pitch_rate_out <= RATE_LIMIT && pitch_rate_out >= -RATE_LIMIT)
		else begin
			fail_count++;
			$error("rate output beyond RATE_LIMIT");
		end

	outputs_match_model: assert property (@(posedge us_clk) disable iff (!resetn)
		complete_signal |-> longint'(yaw_rate_out) == yaw_exp
			&& longint'(roll_rate_out) == roll_exp
			&& longint'(pitch_rate_out) == pitch_exp)
		else begin
			fail_count++;
			$error("PID result mismatch: yaw %0d/%0d roll %0d/%0d pitch %0d/%0d",
				yaw_rate_out, yaw_exp, roll_rate_out, roll_exp,
				pitch_rate_out, pitch_exp);
		end

endmodule

bind body_frame_controller body_frame_controller_props props0 (
	.us_clk(us_clk), .resetn(resetn), .arm(arm),
	.yaw_target(yaw_target), .roll_target(roll_target), .pitch_target(pitch_target),
	.yaw_rotation(yaw_rotation), .roll_rotation(roll_rotation),
	.pitch_rotation(pitch_rotation),
	.yaw_rate_out(yaw_rate_out), .roll_rate_out(roll_rate_out),
	.pitch_rate_out(pitch_rate_out), .complete_signal(complete_signal)
);

`default_nettype wire

// ==== design/body_frame_controller.sv ====
// Body-frame rate controller top
`timescale 1ns/100ps
`default_nettype none

module body_frame_controller #(
	parameter int LOOP_PERIOD = 16,
	parameter int YAW_KP      = 6,
	parameter int YAW_KI      = 1,
	parameter int YAW_KD      = 0,
	parameter int ROLL_KP     = 8,
	parameter int ROLL_KI     = 1,
	parameter int ROLL_KD     = 4,
	parameter int PITCH_KP    = 8,
	parameter int PITCH_KI    = 1,
	parameter int PITCH_KD    = 4,
	parameter int GAIN_SHIFT  = 3,
	parameter int RATE_LIMIT  = 250 << rate_ctrl_pkg::FRAC_BITS,
	parameter int INT_LIMIT   = 16000
) (
	input  wire                                    us_clk,
	input  wire                                    resetn,
	input  wire                                    arm,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0] yaw_target,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0] roll_target,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0] pitch_target,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0] yaw_rotation,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0] roll_rotation,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0] pitch_rotation,
	output wire signed [rate_ctrl_pkg::RATE_W-1:0] yaw_rate_out,
	output wire signed [rate_ctrl_pkg::RATE_W-1:0] roll_rate_out,
	output wire signed [rate_ctrl_pkg::RATE_W-1:0] pitch_rate_out,
	output wire                                    complete_signal
);

	import rate_ctrl_pkg::*;

	logic update_strobe;
	logic axis_go;
	logic clear_state;

	// Latched, sign-corrected axis inputs
	logic signed [RATE_W-1:0] yaw_tgt_q;
	logic signed [RATE_W-1:0] roll_tgt_q;
	logic signed [RATE_W-1:0] pitch_tgt_q;
	logic signed [RATE_W-1:0] yaw_act_q;
	logic signed [RATE_W-1:0] roll_act_q;
	logic signed [RATE_W-1:0] pitch_act_q;

	// Per-axis status
	logic yaw_done;
	logic roll_done;
	logic pitch_done;

	rate_loop_timer #(
		.LOOP_PERIOD(LOOP_PERIOD)
	) timer0 (
		.us_clk       (us_clk),
		.resetn       (resetn),
		.arm          (arm),
		.update_strobe(update_strobe)
	);

	body_frame_sequencer seq0 (
		.us_clk         (us_clk),
		.resetn         (resetn),
		.arm            (arm),
		.update_strobe  (update_strobe),
		.yaw_target     (yaw_target),
		.roll_target    (roll_target),
		.pitch_target   (pitch_target),
		.yaw_rotation   (yaw_rotation),
		.roll_rotation  (roll_rotation),
		.pitch_rotation (pitch_rotation),
		.axis_done_yaw  (yaw_done),
		.axis_done_roll (roll_done),
		.axis_done_pitch(pitch_done),
		.axis_go        (axis_go),
		.clear_state    (clear_state),
		.yaw_tgt_q      (yaw_tgt_q),
		.roll_tgt_q     (roll_tgt_q),
		.pitch_tgt_q    (pitch_tgt_q),
		.yaw_act_q      (yaw_act_q),
		.roll_act_q     (roll_act_q),
		.pitch_act_q    (pitch_act_q),
		.complete_signal(complete_signal)
	);

	pid_axis #(
		.KP(YAW_KP), .KI(YAW_KI), .KD(YAW_KD),
		.GAIN_SHIFT(GAIN_SHIFT), .RATE_LIMIT(RATE_LIMIT), .INT_LIMIT(INT_LIMIT)
	) yaw_pid (
		.us_clk(us_clk), .resetn(resetn),
		.axis_go(axis_go), .clear_state(clear_state),
		.target_rate(yaw_tgt_q), .actual_rate(yaw_act_q),
		.rate_out(yaw_rate_out), .axis_busy(), .axis_done(yaw_done)
	);

	pid_axis #(
		.KP(ROLL_KP), .KI(ROLL_KI), .KD(ROLL_KD),
		.GAIN_SHIFT(GAIN_SHIFT), .RATE_LIMIT(RATE_LIMIT), .INT_LIMIT(INT_LIMIT)
	) roll_pid (
		.us_clk(us_clk), .resetn(resetn),
		.axis_go(axis_go), .clear_state(clear_state),
		.target_rate(roll_tgt_q), .actual_rate(roll_act_q),
		.rate_out(roll_rate_out), .axis_busy(), .axis_done(roll_done)
	);

	pid_axis #(
		.KP(PITCH_KP), .KI(PITCH_KI), .KD(PITCH_KD),
		.GAIN_SHIFT(GAIN_SHIFT), .RATE_LIMIT(RATE_LIMIT), .INT_LIMIT(INT_LIMIT)
	) pitch_pid (
		.us_clk(us_clk), .resetn(resetn),
		.axis_go(axis_go), .clear_state(clear_state),
		.target_rate(pitch_tgt_q), .actual_rate(pitch_act_q),
		.rate_out(pitch_rate_out), .axis_busy(), .axis_done(pitch_done)
	);

endmodule

`default_nettype wire

// ==== design/pid_axis.sv ====
// PID controller for one rate axis
`timescale 1ns/100ps
`default_nettype none

module pid_axis #(
	parameter int KP         = 8,
	parameter int KI         = 1,
	parameter int KD         = 4,
	parameter int GAIN_SHIFT = 3,
	parameter int RATE_LIMIT = 4000,
	parameter int INT_LIMIT  = 16000
) (
	input  wire                                     us_clk,
	input  wire                                     resetn,
	input  wire                                     axis_go,
	input  wire                                     clear_state,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0]  target_rate,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0]  actual_rate,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] rate_out,
	output logic                                    axis_busy,
	output logic                                    axis_done
);

	import rate_ctrl_pkg::*;

	// Gains and limits at accumulator width
	localparam logic signed [ACC_W-1:0] KP_A     = ACC_W'(KP);
	localparam logic signed [ACC_W-1:0] KI_A     = ACC_W'(KI);
	localparam logic signed [ACC_W-1:0] KD_A     = ACC_W'(KD);
	localparam logic signed [ACC_W-1:0] RATE_MAX = ACC_W'(RATE_LIMIT);
	localparam logic signed [ACC_W-1:0] RATE_MIN = -RATE_MAX;
	localparam logic signed [ACC_W-1:0] INT_MAX  = ACC_W'(INT_LIMIT);
	localparam logic signed [ACC_W-1:0] INT_MIN  = -INT_MAX;

	// One valid bit per step, a single update in flight
	logic [3:0] stage_v;

	// Loop history
	logic signed [ACC_W-1:0] integ;
	logic signed [ERR_W-1:0] prev_err;

	// Pipeline payload
	logic signed [ERR_W-1:0]  err_q;
	logic signed [ACC_W-1:0]  deriv_q;
	logic signed [ACC_W-1:0]  p_term;
	logic signed [ACC_W-1:0]  i_term;
	logic signed [ACC_W-1:0]  d_term;
	logic signed [RATE_W-1:0] result_q;

	// Next values
	logic signed [ERR_W-1:0]  err_next;
	logic signed [ACC_W-1:0]  err_ext;
	logic signed [ACC_W-1:0]  integ_sum;
	logic signed [ACC_W-1:0]  integ_next;
	logic signed [ACC_W-1:0]  term_sum;
	logic signed [ACC_W-1:0]  scaled;
	logic signed [RATE_W-1:0] result_next;

	// Step 1, error at one bit wider than the rates
	assign err_next = ERR_W'(target_rate) - ERR_W'(actual_rate);
	assign err_ext  = ACC_W'(err_q);

	// Step 2, integrator with anti-windup clamp
	always_comb begin
		integ_sum = integ + err_ext;
		if (integ_sum > INT_MAX) begin
			integ_next = INT_MAX;
		end else if (integ_sum < INT_MIN) begin
			integ_next = INT_MIN;
		end else begin
			integ_next = integ_sum;
		end
	end

	// Step 4, common gain shift then output clamp
	always_comb begin
		term_sum = p_term + i_term + d_term;
		scaled   = term_sum >>> GAIN_SHIFT;
		if (scaled > RATE_MAX) begin
			result_next = RATE_W'(RATE_MAX);
		end else if (scaled < RATE_MIN) begin
			result_next = RATE_W'(RATE_MIN);
		end else begin
			result_next = RATE_W'(scaled);
		end
	end

	// Control, history and the held output
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			stage_v   <= '0;
			axis_done <= 1'b0;
			integ     <= '0;
			prev_err  <= '0;
			rate_out  <= '0;
		end else if (clear_state) begin
			// Disarmed, drop the update in flight and forget history
			stage_v   <= '0;
			axis_done <= 1'b0;
			integ     <= '0;
			prev_err  <= '0;
		end else begin
			stage_v   <= {stage_v[2:0], axis_go};
			axis_done <= stage_v[3];
			if (stage_v[0]) begin
				integ <= integ_next;
			end
			if (stage_v[3]) begin
				prev_err <= err_q;
			end
			// Output moves on the edge after done
			if (axis_done) begin
				rate_out <= result_q;
			end
		end
	end

	// Datapath registers
	always_ff @(posedge us_clk) begin
		if (axis_go) begin
			err_q <= err_next;
		end
		if (stage_v[0]) begin
			deriv_q <= err_ext - ACC_W'(prev_err);
		end
		// Step 3, the three products
		if (stage_v[1]) begin
			p_term <= err_ext * KP_A;
			i_term <= integ * KI_A;
			d_term <= deriv_q * KD_A;
		end
		if (stage_v[2]) begin
			result_q <= result_next;
		end
	end

	assign axis_busy = |stage_v;

endmodule

`default_nettype wire

// ==== design/body_frame_sequencer.sv ====
// Body-frame rate loop sequencer
`timescale 1ns/100ps
`default_nettype none

module body_frame_sequencer (
	input  wire                                     us_clk,
	input  wire                                     resetn,
	input  wire                                     arm,
	input  wire                                     update_strobe,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0]  yaw_target,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0]  roll_target,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0]  pitch_target,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0]  yaw_rotation,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0]  roll_rotation,
	input  wire signed [rate_ctrl_pkg::RATE_W-1:0]  pitch_rotation,
	input  wire                                     axis_done_yaw,
	input  wire                                     axis_done_roll,
	input  wire                                     axis_done_pitch,
	output logic                                    axis_go,
	output logic                                    clear_state,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] yaw_tgt_q,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] roll_tgt_q,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] pitch_tgt_q,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] yaw_act_q,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] roll_act_q,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] pitch_act_q,
	output logic                                    complete_signal
);

	import rate_ctrl_pkg::*;

	seq_state_t state;
	seq_state_t next_state;
	logic       latch_en;
	logic       all_done;

	// Negate, with the most negative code mapped to the maximum
	function automatic logic signed [RATE_W-1:0] neg_sat(
		input logic signed [RATE_W-1:0] x
	);
		if (x == {1'b1, {(RATE_W-1){1'b0}}}) begin
			return {1'b0, {(RATE_W-1){1'b1}}};
		end else begin
			return -x;
		end
	endfunction

	// Take a new sample only from the idle state
	assign latch_en = (state == SEQ_WAIT) && update_strobe && arm;

	// Axes share a fixed latency, so their done pulses coincide
	assign all_done = axis_done_yaw && axis_done_roll && axis_done_pitch;

	always_comb begin
		next_state = state;
		case (state)
			SEQ_WAIT: begin
				if (latch_en) begin
					next_state = SEQ_START;
				end
			end
			SEQ_START: begin
				next_state = SEQ_ACTIVE;
			end
			SEQ_ACTIVE: begin
				if (all_done) begin
					next_state = SEQ_DONE;
				end
			end
			SEQ_DONE: begin
				next_state = SEQ_WAIT;
			end
			default: begin
				next_state = SEQ_WAIT;
			end
		endcase
		// Disarm abandons whatever update is in flight
		if (!arm) begin
			next_state = SEQ_WAIT;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= SEQ_WAIT;
		end else begin
			state <= next_state;
		end
	end

	// Input latches, body-frame sign fixed here for yaw and pitch
	always_ff @(posedge us_clk) begin
		if (latch_en) begin
			yaw_tgt_q   <= yaw_target;
			roll_tgt_q  <= roll_target;
			pitch_tgt_q <= pitch_target;
			yaw_act_q   <= neg_sat(yaw_rotation);
			roll_act_q  <= roll_rotation;
			pitch_act_q <= neg_sat(pitch_rotation);
		end
	end

	assign axis_go         = (state == SEQ_START);
	assign complete_signal = (state == SEQ_DONE);

	// Axes wipe their history for as long as arm is low
	assign clear_state = !arm;

endmodule

`default_nettype wire

// ==== design/rate_loop_timer.sv ====
// Rate loop update timer
`timescale 1ns/100ps
`default_nettype none

module rate_loop_timer #(
	parameter int LOOP_PERIOD = 16
) (
	input  wire  us_clk,
	input  wire  resetn,
	input  wire  arm,
	output logic update_strobe
);

	// Counter only has to hold LOOP_PERIOD-1 down to zero
	localparam int CNT_W = $clog2(LOOP_PERIOD);
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(LOOP_PERIOD - 1);

	logic [CNT_W-1:0] count;

	// Down-counter, parked at the reload value while disarmed
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			count <= RELOAD;
		end else if (!arm) begin
			count <= RELOAD;
		end else if (count == '0) begin
			// Wrap starts the next control period
			count <= RELOAD;
		end else begin
			count <= count - 1'b1;
		end
	end

	// Strobe for the single cycle the counter sits at zero
	// Gated by arm so a disarm stops it at once
	assign update_strobe = arm && (count == '0);

endmodule

`default_nettype wire

// ==== design/rate_ctrl_pkg.sv ====
// Rate control shared definitions
`default_nettype none

package rate_ctrl_pkg;

	// Target and output rates, signed 12.4 fixed point
	localparam int RATE_W = 16;

	// Fractional bits of the rate format
	localparam int FRAC_BITS = 4;

	// One extra bit so target minus actual never wraps
	localparam int ERR_W = RATE_W + 1;

	// Products, integrator and term sum
	localparam int ACC_W = 32;

	// Sequencer states, one-hot
	// WAIT idles until the loop strobe
	// START holds the latched inputs while the axes are kicked off
	// ACTIVE covers the fixed PID latency
	// DONE lasts one cycle and marks fresh outputs
	typedef enum logic [3:0] {
		SEQ_WAIT   = 4'b0001,
		SEQ_START  = 4'b0010,
		SEQ_ACTIVE = 4'b0100,
		SEQ_DONE   = 4'b1000
	} seq_state_t;

endpackage

`default_nettype wire
